//--- verilog/mips_pkg.sv
package mips_pkg;

    localparam int DATA_W      = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int IMEM_ADDR_W = 8;
    localparam int DMEM_ADDR_W = 6;

    // Primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_HALT    = 6'h3f;

    // SPECIAL function field
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    localparam logic [2:0] ALU_ADD = 3'd0;
    localparam logic [2:0] ALU_SUB = 3'd1;
    localparam logic [2:0] ALU_AND = 3'd2;
    localparam logic [2:0] ALU_OR  = 3'd3;
    localparam logic [2:0] ALU_SLT = 3'd4;

    // Destination register select
    localparam logic [1:0] DEST_NONE = 2'd0;
    localparam logic [1:0] DEST_RD   = 2'd1;
    localparam logic [1:0] DEST_RT   = 2'd2;

    typedef union packed {
        struct packed {
            logic [5:0]            opcode;
            logic [REG_ADDR_W-1:0] rs;
            logic [REG_ADDR_W-1:0] rt;
            logic [REG_ADDR_W-1:0] rd;
            logic [4:0]            shamt;
            logic [5:0]            funct;
        } r;
        struct packed {
            logic [5:0]            opcode;
            logic [REG_ADDR_W-1:0] rs;
            logic [REG_ADDR_W-1:0] rt;
            logic [15:0]           imm;
        } i;
    } instr_t;

    typedef struct packed {
        logic       reg_write;
        logic       mem_read;
        logic       mem_write;
        logic       branch;
        logic       alu_src;
        logic       halt;
        logic [1:0] dest_sel;
    } ctrl_t;

    typedef struct packed {
        logic [DATA_W-1:0] pc4;
        instr_t            instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [2:0]            alu_op;
        logic [DATA_W-1:0]     rs_val;
        logic [DATA_W-1:0]     rt_val;
        logic [DATA_W-1:0]     imm;
        logic [DATA_W-1:0]     pc4;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] dest;
    } id_ex_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [DATA_W-1:0]     alu_result;
        logic                  zero;
        logic [DATA_W-1:0]     branch_target;
        logic [DATA_W-1:0]     store_data;
        logic [REG_ADDR_W-1:0] dest;
    } ex_mem_t;

    typedef struct packed {
        logic                  reg_write;
        logic                  halt;
        logic [REG_ADDR_W-1:0] dest;
        logic [DATA_W-1:0]     result;
    } mem_wb_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] dest;
        logic [DATA_W-1:0]     value;
    } fwd_t;

endpackage

//--- verilog/mips_fetch.sv
`timescale 1ns/1ps

module mips_fetch (
    input  logic                             i_clk,
    input  logic                             i_rst,
    input  logic                             i_stall,
    input  logic                             i_hold,
    input  logic                             i_branch_taken,
    input  logic [mips_pkg::DATA_W-1:0]      i_branch_target,
    input  logic [mips_pkg::IMEM_ADDR_W-1:0] i_imem_addr,
    input  logic [mips_pkg::DATA_W-1:0]      i_imem_data,
    input  logic                             i_imem_we,
    output logic [mips_pkg::DATA_W-1:0]      o_pc,
    output mips_pkg::if_id_t                 o_if_id
);
    import mips_pkg::*;

    logic [DATA_W-1:0] imem [2**IMEM_ADDR_W];
    logic [DATA_W-1:0] pc4;

    assign pc4 = o_pc + DATA_W'(4);

    // Loader port stays live during reset
    always_ff @(posedge i_clk) begin
        if (i_imem_we) begin
            imem[i_imem_addr] <= i_imem_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_pc <= '0;
        end else if (i_branch_taken) begin
            o_pc <= i_branch_target;
        end else if (!i_stall && !i_hold) begin
            o_pc <= pc4;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst || i_branch_taken) begin
            o_if_id <= '0;
        end else if (!i_stall) begin
            o_if_id.pc4   <= pc4;
            o_if_id.instr <= imem[o_pc[IMEM_ADDR_W+1:2]];
        end
    end

    // Hold is sticky until a branch, and the PC stays put meanwhile
    a_pc_held: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_hold && !i_branch_taken) |=> (i_hold && $stable(o_pc)));

endmodule

//--- verilog/mips_decode.sv
`timescale 1ns/1ps

module mips_decode (
    input  logic                            i_clk,
    input  logic                            i_rst,
    input  mips_pkg::if_id_t                i_if_id,
    input  logic                            i_flush,
    input  mips_pkg::mem_wb_t               i_wb,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_dbg_reg,
    output logic [mips_pkg::DATA_W-1:0]     o_dbg_data,
    output logic                            o_stall,
    output logic                            o_hold,
    output mips_pkg::id_ex_t                o_id_ex
);
    import mips_pkg::*;

    logic [DATA_W-1:0] regs [2**REG_ADDR_W];
    instr_t            instr;
    ctrl_t             ctrl;
    logic [2:0]        alu_op;
    logic              use_rs;
    logic              use_rt;
    logic [DATA_W-1:0] rs_val;
    logic [DATA_W-1:0] rt_val;
    logic              load_use;
    logic              halted;
    id_ex_t            id_ex_d;

    assign instr = i_if_id.instr;

    always_comb begin
        ctrl   = '0;
        alu_op = ALU_ADD;
        use_rs = 1'b0;
        use_rt = 1'b0;
        case (instr.r.opcode)
            OP_SPECIAL: begin
                use_rs         = 1'b1;
                use_rt         = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.dest_sel  = DEST_RD;
                case (instr.r.funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_SLT:  alu_op = ALU_SLT;
                    default: ctrl   = '0;
                endcase
            end
            OP_ADDIU, OP_LW: begin
                use_rs         = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = (instr.i.opcode == OP_LW);
                ctrl.alu_src   = 1'b1;
                ctrl.dest_sel  = DEST_RT;
            end
            OP_SW: begin
                use_rs         = 1'b1;
                use_rt         = 1'b1;
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            OP_BEQ: begin
                use_rs      = 1'b1;
                use_rt      = 1'b1;
                ctrl.branch = 1'b1;
                alu_op      = ALU_SUB;
            end
            OP_HALT: ctrl.halt = 1'b1;
            default: ctrl = '0;
        endcase
    end

    // Written at the edge with a bypass so a same-cycle read sees the new value
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int k = 0; k < 2**REG_ADDR_W; k++) begin
                regs[k] <= '0;
            end
        end else if (i_wb.reg_write && i_wb.dest != '0) begin
            regs[i_wb.dest] <= i_wb.result;
        end
    end

    assign rs_val = (i_wb.reg_write && i_wb.dest != '0 && i_wb.dest == instr.i.rs) ?
                    i_wb.result : regs[instr.i.rs];
    assign rt_val = (i_wb.reg_write && i_wb.dest != '0 && i_wb.dest == instr.i.rt) ?
                    i_wb.result : regs[instr.i.rt];
    assign o_dbg_data = regs[i_dbg_reg];

    // Load in ID/EX feeding the instruction behind it
    assign load_use = o_id_ex.ctrl.mem_read && o_id_ex.dest != '0 &&
                      ((use_rs && o_id_ex.dest == instr.i.rs) ||
                       (use_rt && o_id_ex.dest == instr.i.rt));
    assign o_stall  = load_use && !halted;
    assign o_hold   = halted || ctrl.halt;

    // Set once HALT issues, so nothing behind it follows
    always_ff @(posedge i_clk) begin
        if (i_rst || i_flush) begin
            halted <= 1'b0;
        end else if (ctrl.halt) begin
            halted <= 1'b1;
        end
    end

    always_comb begin
        id_ex_d.ctrl   = ctrl;
        id_ex_d.alu_op = alu_op;
        id_ex_d.rs_val = rs_val;
        id_ex_d.rt_val = rt_val;
        id_ex_d.imm    = {{(DATA_W-16){instr.i.imm[15]}}, instr.i.imm};
        id_ex_d.pc4    = i_if_id.pc4;
        id_ex_d.rs     = instr.i.rs;
        id_ex_d.rt     = instr.i.rt;
        case (ctrl.dest_sel)
            DEST_RD: id_ex_d.dest = instr.r.rd;
            DEST_RT: id_ex_d.dest = instr.i.rt;
            default: id_ex_d.dest = '0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        o_id_ex <= id_ex_d;
        if (i_rst || i_flush || o_stall || halted) begin
            o_id_ex.ctrl <= '0;
        end
    end

    // The bubble clears the hazard, so a stall lasts one cycle
    a_stall_bubble: assert property (@(posedge i_clk) disable iff (i_rst)
        o_stall |=> (o_id_ex.ctrl == '0 && !o_stall));

endmodule

//--- verilog/mips_execute.sv
`timescale 1ns/1ps

module mips_execute (
    input  logic              i_clk,
    input  logic              i_rst,
    input  mips_pkg::id_ex_t  i_id_ex,
    input  logic              i_flush,
    input  mips_pkg::fwd_t    i_fwd_mem,
    input  mips_pkg::fwd_t    i_fwd_wb,
    output mips_pkg::ex_mem_t o_ex_mem
);
    import mips_pkg::*;

    logic [DATA_W-1:0] op_a;
    logic [DATA_W-1:0] rt_fwd;
    logic [DATA_W-1:0] op_b;
    logic [DATA_W-1:0] alu_y;
    ex_mem_t           ex_mem_d;

    // Youngest producer wins, register 0 is never forwarded
    function automatic logic [DATA_W-1:0] forward(
        input logic [REG_ADDR_W-1:0] src,
        input logic [DATA_W-1:0]     reg_val,
        input fwd_t                  fwd_mem,
        input fwd_t                  fwd_wb
    );
        if (src == '0) begin
            return reg_val;
        end
        if (fwd_mem.valid && fwd_mem.dest == src) begin
            return fwd_mem.value;
        end
        if (fwd_wb.valid && fwd_wb.dest == src) begin
            return fwd_wb.value;
        end
        return reg_val;
    endfunction

    assign op_a   = forward(i_id_ex.rs, i_id_ex.rs_val, i_fwd_mem, i_fwd_wb);
    assign rt_fwd = forward(i_id_ex.rt, i_id_ex.rt_val, i_fwd_mem, i_fwd_wb);
    assign op_b   = i_id_ex.ctrl.alu_src ? i_id_ex.imm : rt_fwd;

    always_comb begin
        case (i_id_ex.alu_op)
            ALU_ADD: alu_y = op_a + op_b;
            ALU_SUB: alu_y = op_a - op_b;
            ALU_AND: alu_y = op_a & op_b;
            ALU_OR:  alu_y = op_a | op_b;
            ALU_SLT: alu_y = {{(DATA_W-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
            default: alu_y = '0;
        endcase
    end

    always_comb begin
        ex_mem_d.ctrl          = i_id_ex.ctrl;
        ex_mem_d.alu_result    = alu_y;
        ex_mem_d.zero          = (alu_y == '0);
        // Word offset relative to the next instruction
        ex_mem_d.branch_target = i_id_ex.pc4 + (i_id_ex.imm << 2);
        ex_mem_d.store_data    = rt_fwd;
        ex_mem_d.dest          = i_id_ex.dest;
    end

    always_ff @(posedge i_clk) begin
        o_ex_mem <= ex_mem_d;
        if (i_rst || i_flush) begin
            o_ex_mem.ctrl <= '0;
        end
    end

endmodule

//--- verilog/mips_memory.sv
`timescale 1ns/1ps

module mips_memory (
    input  logic                             i_clk,
    input  logic                             i_rst,
    input  mips_pkg::ex_mem_t                i_ex_mem,
    input  logic [mips_pkg::DMEM_ADDR_W-1:0] i_dbg_addr,
    output logic [mips_pkg::DATA_W-1:0]      o_dbg_data,
    output logic                             o_branch_taken,
    output logic [mips_pkg::DATA_W-1:0]      o_branch_target,
    output mips_pkg::fwd_t                   o_fwd_mem,
    output mips_pkg::fwd_t                   o_fwd_wb,
    output mips_pkg::mem_wb_t                o_mem_wb,
    output logic                             o_halt
);
    import mips_pkg::*;

    logic [DATA_W-1:0]      dmem [2**DMEM_ADDR_W];
    logic [DMEM_ADDR_W-1:0] addr;
    logic [DATA_W-1:0]      result;

    assign addr            = i_ex_mem.alu_result[DMEM_ADDR_W+1:2];
    assign o_branch_taken  = i_ex_mem.ctrl.branch && i_ex_mem.zero;
    assign o_branch_target = i_ex_mem.branch_target;
    assign result          = i_ex_mem.ctrl.mem_read ? dmem[addr] : i_ex_mem.alu_result;
    assign o_dbg_data      = dmem[i_dbg_addr];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int k = 0; k < 2**DMEM_ADDR_W; k++) begin
                dmem[k] <= '0;
            end
        end else if (i_ex_mem.ctrl.mem_write) begin
            dmem[addr] <= i_ex_mem.store_data;
        end
    end

    // Load data is not ready here, the load-use stall covers it
    always_comb begin
        o_fwd_mem.valid = i_ex_mem.ctrl.reg_write && !i_ex_mem.ctrl.mem_read;
        o_fwd_mem.dest  = i_ex_mem.dest;
        o_fwd_mem.value = i_ex_mem.alu_result;
        o_fwd_wb.valid  = o_mem_wb.reg_write;
        o_fwd_wb.dest   = o_mem_wb.dest;
        o_fwd_wb.value  = o_mem_wb.result;
    end

    always_ff @(posedge i_clk) begin
        o_mem_wb.dest   <= i_ex_mem.dest;
        o_mem_wb.result <= result;
        if (i_rst) begin
            o_mem_wb.reg_write <= 1'b0;
            o_mem_wb.halt      <= 1'b0;
        end else begin
            o_mem_wb.reg_write <= i_ex_mem.ctrl.reg_write;
            o_mem_wb.halt      <= i_ex_mem.ctrl.halt;
        end
    end

    // Sticky until reset
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_halt <= 1'b0;
        end else if (o_mem_wb.halt) begin
            o_halt <= 1'b1;
        end
    end

    a_rd_wr_excl: assert property (@(posedge i_clk) disable iff (i_rst)
        !(i_ex_mem.ctrl.mem_read && i_ex_mem.ctrl.mem_write));

endmodule

//--- verilog/mips_top.sv
`timescale 1ns/1ps

module mips_top (
    input  logic                             i_clk,
    input  logic                             i_rst,
    input  logic [mips_pkg::REG_ADDR_W-1:0]  i_select_reg_dir,
    input  logic [mips_pkg::DMEM_ADDR_W-1:0] i_select_mem_dir,
    input  logic [mips_pkg::IMEM_ADDR_W-1:0] i_select_mem_ins_dir,
    input  logic [mips_pkg::DATA_W-1:0]      i_dato_mem_ins,
    input  logic                             i_write_mem_ins,
    output logic [mips_pkg::DATA_W-1:0]      o_pc,
    output logic [mips_pkg::DATA_W-1:0]      o_data_reg_file,
    output logic [mips_pkg::DATA_W-1:0]      o_data_mem,
    output logic                             o_mips_halt
);
    import mips_pkg::*;

    if_id_t            if_id;
    id_ex_t            id_ex;
    ex_mem_t           ex_mem;
    mem_wb_t           mem_wb;
    fwd_t              fwd_mem;
    fwd_t              fwd_wb;
    logic              stall;
    logic              hold;
    logic              branch_taken;
    logic [DATA_W-1:0] branch_target;

    mips_fetch u_fetch (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_stall         (stall),
        .i_hold          (hold),
        .i_branch_taken  (branch_taken),
        .i_branch_target (branch_target),
        .i_imem_addr     (i_select_mem_ins_dir),
        .i_imem_data     (i_dato_mem_ins),
        .i_imem_we       (i_write_mem_ins),
        .o_pc            (o_pc),
        .o_if_id         (if_id)
    );

    mips_decode u_decode (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_if_id    (if_id),
        .i_flush    (branch_taken),
        .i_wb       (mem_wb),
        .i_dbg_reg  (i_select_reg_dir),
        .o_dbg_data (o_data_reg_file),
        .o_stall    (stall),
        .o_hold     (hold),
        .o_id_ex    (id_ex)
    );

    mips_execute u_execute (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_id_ex   (id_ex),
        .i_flush   (branch_taken),
        .i_fwd_mem (fwd_mem),
        .i_fwd_wb  (fwd_wb),
        .o_ex_mem  (ex_mem)
    );

    mips_memory u_memory (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_ex_mem        (ex_mem),
        .i_dbg_addr      (i_select_mem_dir),
        .o_dbg_data      (o_data_mem),
        .o_branch_taken  (branch_taken),
        .o_branch_target (branch_target),
        .o_fwd_mem       (fwd_mem),
        .o_fwd_wb        (fwd_wb),
        .o_mem_wb        (mem_wb),
        .o_halt          (o_mips_halt)
    );

endmodule

//--- dv/mips_tb.sv
`timescale 1ns/1ps

module mips_tb;
    import mips_pkg::*;

    localparam int  CLK_PERIOD     = 100;
    localparam int  NUM_TESTS      = 4;
    localparam int  PROG_LEN       = 48;
    localparam int  RST_CYCLES     = 8;
    localparam int  READBACK       = 2**REG_ADDR_W + 2**DMEM_ADDR_W;
    localparam int  TIMEOUT_CYCLES =
        2 * NUM_TESTS * (PROG_LEN + RST_CYCLES + 2 * PROG_LEN + READBACK) + 16;

    logic                   i_clk;
    logic                   i_rst;
    logic [REG_ADDR_W-1:0]  i_select_reg_dir;
    logic [DMEM_ADDR_W-1:0] i_select_mem_dir;
    logic [IMEM_ADDR_W-1:0] i_select_mem_ins_dir;
    logic [DATA_W-1:0]      i_dato_mem_ins;
    logic                   i_write_mem_ins;
    logic [DATA_W-1:0]      o_pc;
    logic [DATA_W-1:0]      o_data_reg_file;
    logic [DATA_W-1:0]      o_data_mem;
    logic                   o_mips_halt;

    logic [31:0]       rng_state;
    logic [DATA_W-1:0] prog [PROG_LEN];
    logic [DATA_W-1:0] m_regs [2**REG_ADDR_W];
    logic [DATA_W-1:0] m_mem [2**DMEM_ADDR_W];
    logic [DATA_W-1:0] m_halt_pc;
    int                m_steps;
    int                cycles;
    int                checks;
    int                errors;
    int                errs_before;
    int                failed_tests;

    mips_top UUT (
        .i_clk                (i_clk),
        .i_rst                (i_rst),
        .i_select_reg_dir     (i_select_reg_dir),
        .i_select_mem_dir     (i_select_mem_dir),
        .i_select_mem_ins_dir (i_select_mem_ins_dir),
        .i_dato_mem_ins       (i_dato_mem_ins),
        .i_write_mem_ins      (i_write_mem_ins),
        .o_pc                 (o_pc),
        .o_data_reg_file      (o_data_reg_file),
        .o_data_mem           (o_data_mem),
        .o_mips_halt          (o_mips_halt)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge i_clk);
            cycles++;
        end
        $display("timeout: the DUT never raised its halt output within %0d cycles",
                 TIMEOUT_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic logic [DATA_W-1:0] make_rtype(input logic [5:0] funct,
        input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] rd);
        return {OP_SPECIAL, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [DATA_W-1:0] make_itype(input logic [5:0] op,
        input logic [4:0] rs, input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [5:0] pick_funct(input int sel);
        case (sel % 5)
            0:       return FN_ADDU;
            1:       return FN_SUBU;
            2:       return FN_AND;
            3:       return FN_OR;
            default: return FN_SLT;
        endcase
    endfunction

    task automatic next_cycle();
        @(posedge i_clk);
        #5;
    endtask

    // Registers 0..7 only, so hazards and equal BEQ operands are common
    task automatic gen_program();
        logic [31:0] r;
        logic [31:0] v;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        logic [15:0] offs;
        int          skip;
        for (int i = 0; i < PROG_LEN - 1; i++) begin
            r    = next_rand();
            v    = next_rand();
            rs   = {2'b00, r[28:26]};
            rt   = {2'b00, r[25:23]};
            rd   = {2'b00, r[22:20]};
            imm  = v[31] ? v[15:0] : {13'd0, v[18:16]};
            offs = {8'd0, v[27:22], 2'b00};
            case (r[31:29])
                3'd0, 3'd1, 3'd2: prog[i] = make_rtype(pick_funct(int'(r[19:16])), rs, rt, rd);
                3'd3, 3'd7:       prog[i] = make_itype(OP_ADDIU, rs, rt, imm);
                3'd4:             prog[i] = make_itype(OP_LW, 5'd0, rt, offs);
                3'd5:             prog[i] = make_itype(OP_SW, 5'd0, rt, offs);
                default: begin
                    // Forward only, landing on HALT at the latest
                    skip = int'(v[21:20]);
                    if (i + skip > PROG_LEN - 2) begin
                        skip = PROG_LEN - 2 - i;
                    end
                    prog[i] = make_itype(OP_BEQ, rs, rt, 16'(skip));
                end
            endcase
        end
        prog[PROG_LEN-1] = {OP_HALT, 26'd0};
    endtask

    // Sequential instruction-set model
    task automatic run_model();
        logic [DATA_W-1:0] w;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] simm;
        logic [DATA_W-1:0] addr;
        int                pc;
        bit                done;
        for (int k = 0; k < 2**REG_ADDR_W; k++) begin
            m_regs[k] = '0;
        end
        for (int k = 0; k < 2**DMEM_ADDR_W; k++) begin
            m_mem[k] = '0;
        end
        pc      = 0;
        done    = 1'b0;
        m_steps = 0;
        while (!done && pc < PROG_LEN) begin
            w    = prog[pc];
            a    = m_regs[w[25:21]];
            b    = m_regs[w[20:16]];
            simm = {{16{w[15]}}, w[15:0]};
            addr = a + simm;
            pc   = pc + 1;
            m_steps++;
            case (w[31:26])
                OP_SPECIAL: begin
                    case (w[5:0])
                        FN_ADDU: m_regs[w[15:11]] = a + b;
                        FN_SUBU: m_regs[w[15:11]] = a - b;
                        FN_AND:  m_regs[w[15:11]] = a & b;
                        FN_OR:   m_regs[w[15:11]] = a | b;
                        FN_SLT:  m_regs[w[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: ;
                    endcase
                end
                OP_ADDIU: m_regs[w[20:16]] = addr;
                OP_LW:    m_regs[w[20:16]] = m_mem[addr[7:2]];
                OP_SW:    m_mem[addr[7:2]] = b;
                OP_BEQ: begin
                    if (a == b) begin
                        pc = pc + int'($signed(simm));
                    end
                end
                OP_HALT: begin
                    m_halt_pc = DATA_W'(4 * pc);
                    done      = 1'b1;
                end
                default: ;
            endcase
            m_regs[0] = '0;
        end
    endtask

    task automatic check_reg(input int idx, input logic [DATA_W-1:0] got,
        input logic [DATA_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0d ns: register %0d reads %h, model has %h",
                     $time, idx, got, exp);
        end
    endtask

    task automatic check_mem(input int idx, input logic [DATA_W-1:0] got,
        input logic [DATA_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0d ns: data word %0d reads %h, model has %h",
                     $time, idx, got, exp);
        end
    endtask

    task automatic check_pc(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0d ns: pc after halt is %h, expected %h", $time, got, exp);
        end
    endtask

    // Written while reset is held
    task automatic load_program();
        for (int i = 0; i < PROG_LEN; i++) begin
            i_select_mem_ins_dir = IMEM_ADDR_W'(i);
            i_dato_mem_ins       = prog[i];
            i_write_mem_ins      = 1'b1;
            next_cycle();
        end
        i_write_mem_ins = 1'b0;
    endtask

    task automatic read_back();
        for (int r = 0; r < 2**REG_ADDR_W; r++) begin
            i_select_reg_dir = REG_ADDR_W'(r);
            next_cycle();
            check_reg(r, o_data_reg_file, m_regs[r]);
        end
        for (int m = 0; m < 2**DMEM_ADDR_W; m++) begin
            i_select_mem_dir = DMEM_ADDR_W'(m);
            next_cycle();
            check_mem(m, o_data_mem, m_mem[m]);
        end
    endtask

    initial begin
        i_rst                = 1'b1;
        i_select_reg_dir     = '0;
        i_select_mem_dir     = '0;
        i_select_mem_ins_dir = '0;
        i_dato_mem_ins       = '0;
        i_write_mem_ins      = 1'b0;
        rng_state            = 32'h7419_63a3;
        checks               = 0;
        errors               = 0;
        failed_tests         = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            errs_before = errors;
            gen_program();
            run_model();
            i_rst = 1'b1;
            load_program();
            repeat (RST_CYCLES) next_cycle();
            i_rst = 1'b0;
            while (o_mips_halt !== 1'b1) begin
                next_cycle();
            end
            check_pc(o_pc, m_halt_pc);
            read_back();
            if (o_mips_halt !== 1'b1) begin
                errors++;
                $display("halt output dropped before reset in test %0d", t);
            end
            if (errors == errs_before) begin
                $display("test %0d passed, %0d instructions executed", t, m_steps);
            end else begin
                failed_tests++;
                $display("test %0d failed with %0d errors", t, errors - errs_before);
            end
        end
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 NUM_TESTS, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- project.f
verilog/mips_pkg.sv
verilog/mips_fetch.sv
verilog/mips_decode.sv
verilog/mips_execute.sv
verilog/mips_memory.sv
verilog/mips_top.sv
dv/mips_tb.sv

//--- Bender.yml
package:
  name: mips_pipeline

sources:
  - files:
      - verilog/mips_pkg.sv
      - verilog/mips_fetch.sv
      - verilog/mips_decode.sv
      - verilog/mips_execute.sv
      - verilog/mips_memory.sv
      - verilog/mips_top.sv
  - target: simulation
    files:
      - dv/mips_tb.sv
